/* osd_config.svh */
/*
 * shared constants for the osd command controller
 * command codes are the upper six bits of a command byte
 */
`ifndef OSD_CONFIG_SVH
`define OSD_CONFIG_SVH

// --------------------
// command codes, byte[7:2]
// --------------------
`define OSD_CMD_RESET_CTRL    6'b0_000_10
`define OSD_CMD_OSD_CTRL      6'b0_010_10
`define OSD_CMD_CHIP_CFG      6'b0_000_01
`define OSD_CMD_MEMORY_CFG    6'b0_010_01
`define OSD_CMD_VIDEO_CFG     6'b0_011_01
`define OSD_CMD_MEM_WRITE     6'b0_001_11
`define OSD_CMD_VERSION       6'b1_000_10

// --------------------
// word fifo and byte counter
// --------------------
// 16 words deep
`define OSD_FIFO_DEPTH_LOG2   4
// count stops here, mem write payload runs at this count
`define OSD_DATA_CNT_MAX      3'd4

// --------------------
// rtl version, returned in this order
// --------------------
`define OSD_VER_BETA          8'h01
`define OSD_VER_MAJOR         8'h02
`define OSD_VER_MINOR         8'h05
`define OSD_VER_SEP           8'h00

// chip ram 1, slow ram 1, no fast, no hrtmon
`define OSD_MEMORY_CFG_RESET  7'b0_00_01_01

`endif

/* osd_pkg.sv */
/*
 * types shared by the osd command controller
 * enum values come from the config header
 */
`include "osd_config.svh"

package osd_pkg;

   // one byte of the command stream
   typedef logic [7:0] osd_byte_t;

   // host bus data word
   typedef logic [15:0] osd_word_t;

   // host bus byte address, 24 bits
   typedef logic [23:0] osd_addr_t;

   // data byte count, saturates at OSD_DATA_CNT_MAX
   typedef logic [2:0] osd_cnt_t;

   // active command
   // unknown codes simply select no target
   typedef enum logic [5:0] {
      OSD_CMD_NONE       = 6'd0,
      OSD_CMD_RESET_CTRL = `OSD_CMD_RESET_CTRL,
      OSD_CMD_OSD_CTRL   = `OSD_CMD_OSD_CTRL,
      OSD_CMD_CHIP_CFG   = `OSD_CMD_CHIP_CFG,
      OSD_CMD_MEMORY_CFG = `OSD_CMD_MEMORY_CFG,
      OSD_CMD_VIDEO_CFG  = `OSD_CMD_VIDEO_CFG,
      OSD_CMD_MEM_WRITE  = `OSD_CMD_MEM_WRITE,
      OSD_CMD_VERSION    = `OSD_CMD_VERSION
   } osd_cmd_t;

   // host write fsm
   // idle: bus released, write: cs held until ack
   typedef enum logic [1:0] {
      HOST_IDLE  = 2'b00,
      HOST_WRITE = 2'b10
   } host_wr_state_t;

endpackage

/* osd_cmd_decoder.sv */
/*
 * command latch and data byte counter
 * each byte is valid for a single clk, no back-pressure
 */
`include "osd_config.svh"

module osd_cmd_decoder (
   input  logic                clk,
   input  logic                reset,
   input  logic                byte_valid,
   input  logic                byte_is_cmd,
   input  osd_pkg::osd_byte_t  byte_data,
   output osd_pkg::osd_cmd_t   cur_cmd,
   output osd_pkg::osd_cnt_t   data_cnt,
   output logic                cmd_strobe
);

   import osd_pkg::*;

   logic cmd_byte;
   logic data_byte;

   // --------------------
   // byte classification
   // --------------------
   assign cmd_byte  = byte_valid & byte_is_cmd;
   assign data_byte = byte_valid & ~byte_is_cmd;

   // --------------------
   // command latch
   // --------------------
   // low two bits of a command byte are unused
   always_ff @(posedge clk) begin
      if (reset) begin
         cur_cmd <= OSD_CMD_NONE;
      end else if (cmd_byte) begin
         cur_cmd <= osd_cmd_t'(byte_data[7:2]);
      end
   end

   // one clk flag after every command byte
   // host writer drops an open cycle on it
   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_strobe <= 1'b0;
      end else begin
         cmd_strobe <= cmd_byte;
      end
   end

   // --------------------
   // data byte counter
   // --------------------
   // counts position inside the command payload
   // holds at max, so mem write data keeps the same count
   always_ff @(posedge clk) begin
      if (reset) begin
         data_cnt <= '0;
      end else if (cmd_byte) begin
         data_cnt <= '0;
      end else if (data_byte && (data_cnt != `OSD_DATA_CNT_MAX)) begin
         data_cnt <= data_cnt + 3'd1;
      end
   end

endmodule

/* osd_config_regs.sv */
/*
 * control and configuration registers, version read-back
 * chipset and memory config are staged and only taken while reset is high
 */
`include "osd_config.svh"

module osd_config_regs (
   input  logic                clk,
   input  logic                reset,
   input  logic                byte_valid,
   input  logic                byte_is_cmd,
   input  osd_pkg::osd_byte_t  byte_data,
   input  osd_pkg::osd_cmd_t   cur_cmd,
   input  osd_pkg::osd_cnt_t   data_cnt,
   input  osd_pkg::osd_byte_t  osd_ctrl,
   output osd_pkg::osd_byte_t  rd_data,
   output logic                usrrst,
   output logic                cpurst,
   output logic                cpuhlt,
   output logic                osd_enable,
   output logic                key_disable,
   output logic [1:0]          scanline,
   output logic [1:0]          lr_filter,
   output logic [1:0]          hr_filter,
   output logic [1:0]          dither,
   output logic [4:0]          chipset_config,
   output logic [6:0]          memory_config
);

   import osd_pkg::*;

   logic      reg_wr;
   // staged copies, power-on values so the first reset loads defaults
   logic [4:0] chip_cfg_stage = 5'd0;
   logic [6:0] mem_cfg_stage  = `OSD_MEMORY_CFG_RESET;

   // only the first payload byte of a command writes
   assign reg_wr = byte_valid & ~byte_is_cmd & (data_cnt == 3'd0);

   // --------------------
   // immediate registers
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         // cpu held in reset and halted until the host releases it
         {cpuhlt, cpurst, usrrst} <= 3'b110;
         {key_disable, osd_enable} <= 2'b00;
         {dither, hr_filter, lr_filter, scanline} <= 8'h00;
      end else if (reg_wr) begin
         case (cur_cmd)
            // xxxxx h r c
            OSD_CMD_RESET_CTRL: {cpuhlt, cpurst, usrrst} <= byte_data[2:0];
            // xxxxxx k e
            OSD_CMD_OSD_CTRL:   {key_disable, osd_enable} <= byte_data[1:0];
            // dd hh ll ss
            OSD_CMD_VIDEO_CFG:
               {dither, hr_filter, lr_filter, scanline} <= byte_data;
            default: ;
         endcase
      end
   end

   // --------------------
   // staged configuration
   // --------------------
   // survives reset, written value applies on the next reset
   always_ff @(posedge clk) begin
      if (reg_wr && (cur_cmd == OSD_CMD_CHIP_CFG)) begin
         chip_cfg_stage <= byte_data[4:0];
      end
      if (reg_wr && (cur_cmd == OSD_CMD_MEMORY_CFG)) begin
         mem_cfg_stage <= byte_data[6:0];
      end
   end

   // outputs follow stage on every reset clk
   always_ff @(posedge clk) begin
      if (reset) begin
         chipset_config <= chip_cfg_stage;
         memory_config  <= mem_cfg_stage;
      end
   end

   // --------------------
   // read-back mux
   // --------------------
   always_comb begin
      rd_data = osd_ctrl;
      if (cur_cmd == OSD_CMD_VERSION) begin
         case (data_cnt)
            3'd0:    rd_data = `OSD_VER_BETA;
            3'd1:    rd_data = `OSD_VER_MAJOR;
            3'd2:    rd_data = `OSD_VER_MINOR;
            default: rd_data = `OSD_VER_SEP;
         endcase
      end
   end

endmodule

/* osd_word_fifo.sv */
/*
 * pairs memory write bytes into words and queues them
 * a push into a full queue is dropped, the sender watches fifo_full
 */
`include "osd_config.svh"

module osd_word_fifo (
   input  logic                clk,
   input  logic                reset,
   input  logic                byte_valid,
   input  logic                byte_is_cmd,
   input  osd_pkg::osd_byte_t  byte_data,
   input  osd_pkg::osd_cmd_t   cur_cmd,
   input  osd_pkg::osd_cnt_t   data_cnt,
   input  logic                fifo_pop,
   output osd_pkg::osd_word_t  fifo_word,
   output logic                fifo_empty,
   output logic                fifo_full
);

   import osd_pkg::*;

   localparam int AW = `OSD_FIFO_DEPTH_LOG2;

   osd_word_t   mem [2**AW];
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   osd_byte_t   hi_byte;
   logic        phase;
   logic        mem_byte;
   logic        push;

   // --------------------
   // byte pairing
   // --------------------
   // payload starts after three address bytes and the page byte
   assign mem_byte = byte_valid & ~byte_is_cmd & (cur_cmd == OSD_CMD_MEM_WRITE)
                     & (data_cnt == `OSD_DATA_CNT_MAX);
   assign push     = mem_byte & phase & ~fifo_full;

   always_ff @(posedge clk) begin
      if (reset || (byte_valid && byte_is_cmd)) begin
         phase <= 1'b0;
      end else if (mem_byte) begin
         phase <= ~phase;
      end
   end

   // first byte of a pair, high half of the word
   always_ff @(posedge clk) begin
      if (mem_byte && !phase) begin
         hi_byte <= byte_data;
      end
   end

   // --------------------
   // circular buffer
   // --------------------
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= {hi_byte, byte_data};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (fifo_pop && !fifo_empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // extra pointer bit tells full from empty
   assign fifo_empty = (wr_ptr == rd_ptr);
   assign fifo_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   // head word, show-ahead
   assign fifo_word  = mem[rd_ptr[AW-1:0]];

endmodule

/* osd_host_writer.sv */
/*
 * host bus write fsm with address counter
 * one 16-bit word per cs cycle, cs held until ack
 * the page byte of a memory write is not part of the address
 */
module osd_host_writer (
   input  logic                clk,
   input  logic                reset,
   input  logic                byte_valid,
   input  logic                byte_is_cmd,
   input  osd_pkg::osd_byte_t  byte_data,
   input  osd_pkg::osd_cmd_t   cur_cmd,
   input  osd_pkg::osd_cnt_t   data_cnt,
   input  logic                cmd_strobe,
   input  logic                fifo_empty,
   input  osd_pkg::osd_word_t  fifo_word,
   input  logic                host_ack,
   output logic                fifo_pop,
   output logic                host_cs,
   output logic                host_we,
   output logic [1:0]          host_bs,
   output osd_pkg::osd_addr_t  host_adr,
   output osd_pkg::osd_word_t  host_wdat
);

   import osd_pkg::*;

   host_wr_state_t state;
   logic           adr_byte;

   // --------------------
   // write fsm
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= HOST_IDLE;
         host_cs  <= 1'b0;
         host_we  <= 1'b0;
         host_bs  <= 2'b00;
         fifo_pop <= 1'b0;
      end else begin
         fifo_pop <= 1'b0;
         if (cmd_strobe) begin
            // abort, word stays queued and is written again later
            state   <= HOST_IDLE;
            host_cs <= 1'b0;
            host_we <= 1'b0;
            host_bs <= 2'b00;
         end else begin
            case (state)
               HOST_IDLE: begin
                  // empty flag is stale on the pop clk
                  if (!fifo_empty && !fifo_pop) begin
                     state   <= HOST_WRITE;
                     host_cs <= 1'b1;
                     host_we <= 1'b1;
                     host_bs <= 2'b11;
                  end
               end
               HOST_WRITE: begin
                  if (host_ack) begin
                     state    <= HOST_IDLE;
                     host_cs  <= 1'b0;
                     host_we  <= 1'b0;
                     host_bs  <= 2'b00;
                     fifo_pop <= 1'b1;
                  end
               end
               default: state <= HOST_IDLE;
            endcase
         end
      end
   end

   // --------------------
   // address counter
   // --------------------
   // payload bytes 0..2 of a memory write, low byte first
   assign adr_byte = byte_valid & ~byte_is_cmd & (cur_cmd == OSD_CMD_MEM_WRITE);

   always_ff @(posedge clk) begin
      if (adr_byte && (data_cnt == 3'd0)) begin
         host_adr[7:0] <= byte_data;
      end else if (adr_byte && (data_cnt == 3'd1)) begin
         host_adr[15:8] <= byte_data;
      end else if (adr_byte && (data_cnt == 3'd2)) begin
         host_adr[23:16] <= byte_data;
      end else if (fifo_pop) begin
         // next word, byte address
         host_adr <= host_adr + 24'd2;
      end
   end

   // head of queue, stable until the pop after ack
   assign host_wdat = fifo_word;

endmodule

/* osd_ctrl_top.sv */
/*
 * osd command controller, byte stream in, config and host bus out
 * memory reads are not supported
 */
module osd_ctrl_top (
   input  logic                clk,
   input  logic                reset,
   // byte stream
   input  logic                byte_valid,
   input  logic                byte_is_cmd,
   input  osd_pkg::osd_byte_t  byte_data,
   // keyboard osd keycode and read-back
   input  osd_pkg::osd_byte_t  osd_ctrl,
   output osd_pkg::osd_byte_t  rd_data,
   // configuration
   output logic                usrrst,
   output logic                cpurst,
   output logic                cpuhlt,
   output logic                osd_enable,
   output logic                key_disable,
   output logic [1:0]          scanline,
   output logic [1:0]          lr_filter,
   output logic [1:0]          hr_filter,
   output logic [1:0]          dither,
   output logic [4:0]          chipset_config,
   output logic [6:0]          memory_config,
   output logic                fifo_full,
   // host bus
   output logic                host_cs,
   output logic                host_we,
   output logic [1:0]          host_bs,
   output osd_pkg::osd_addr_t  host_adr,
   output osd_pkg::osd_word_t  host_wdat,
   input  logic                host_ack
);

   import osd_pkg::*;

   osd_cmd_t  cur_cmd;
   osd_cnt_t  data_cnt;
   logic      cmd_strobe;
   logic      fifo_empty;
   logic      fifo_pop;
   osd_word_t fifo_word;

   // --------------------
   // command and count
   // --------------------
   osd_cmd_decoder u_dec (
      .clk, .reset, .byte_valid, .byte_is_cmd, .byte_data,
      .cur_cmd, .data_cnt, .cmd_strobe
   );

   osd_config_regs u_regs (
      .clk, .reset, .byte_valid, .byte_is_cmd, .byte_data,
      .cur_cmd, .data_cnt, .osd_ctrl, .rd_data,
      .usrrst, .cpurst, .cpuhlt, .osd_enable, .key_disable,
      .scanline, .lr_filter, .hr_filter, .dither,
      .chipset_config, .memory_config
   );

   // --------------------
   // memory write path
   // --------------------
   osd_word_fifo u_fifo (
      .clk, .reset, .byte_valid, .byte_is_cmd, .byte_data,
      .cur_cmd, .data_cnt, .fifo_pop,
      .fifo_word, .fifo_empty, .fifo_full
   );

   osd_host_writer u_host (
      .clk, .reset, .byte_valid, .byte_is_cmd, .byte_data,
      .cur_cmd, .data_cnt, .cmd_strobe, .fifo_empty, .fifo_word, .host_ack,
      .fifo_pop, .host_cs, .host_we, .host_bs, .host_adr, .host_wdat
   );

endmodule

/* osd_ctrl_checker.sv */
/*
 * host bus and config assertions, bound into osd_ctrl_top
 * failures are counted in fail_cnt for the testbench summary
 */
module osd_ctrl_checker (
   input logic               clk,
   input logic               reset,
   input logic               byte_valid,
   input logic               byte_is_cmd,
   input logic [4:0]         chipset_config,
   input logic               host_cs,
   input logic               host_we,
   input logic [1:0]         host_bs,
   input osd_pkg::osd_addr_t host_adr,
   input osd_pkg::osd_word_t host_wdat,
   input logic               host_ack
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_cnt = 0;

   // --------------------
   // configuration
   // --------------------
   // staged chipset value lands only on a reset clk
   chip_cfg_reset_only: assert property (@(posedge clk)
      $changed(chipset_config) |-> $past(reset))
      else begin
         fail_cnt++;
         $error("chipset_config changed while reset was low");
      end

   // --------------------
   // host bus
   // --------------------
   // every cycle is a full word write
   cs_full_write: assert property (@(posedge clk) disable iff (reset)
      host_cs |-> (host_we && (host_bs == 2'b11)))
      else begin
         fail_cnt++;
         $error("host_cs without host_we and both byte selects");
      end

   // address and data held until ack, an abort may end the cycle
   cs_hold_stable: assert property (@(posedge clk) disable iff (reset)
      (host_cs && !host_ack) |=> (!host_cs || ($stable(host_adr) && $stable(host_wdat))))
      else begin
         fail_cnt++;
         $error("host_adr or host_wdat moved before ack");
      end

   ack_ends_cycle: assert property (@(posedge clk) disable iff (reset)
      (host_cs && host_ack) |=> !host_cs)
      else begin
         fail_cnt++;
         $error("host_cs still high the clk after ack");
      end

   // command byte, then strobe, then cs released
   cmd_aborts_cycle: assert property (@(posedge clk) disable iff (reset)
      (byte_valid && byte_is_cmd) |-> ##2 !host_cs)
      else begin
         fail_cnt++;
         $error("host_cs not released after a command byte");
      end

endmodule

bind osd_ctrl_top osd_ctrl_checker u_checker (
   .clk            (clk),
   .reset          (reset),
   .byte_valid     (byte_valid),
   .byte_is_cmd    (byte_is_cmd),
   .chipset_config (chipset_config),
   .host_cs        (host_cs),
   .host_we        (host_we),
   .host_bs        (host_bs),
   .host_adr       (host_adr),
   .host_wdat      (host_wdat),
   .host_ack       (host_ack)
);

/* tb_osd_ctrl.sv */
/*
 * testbench for osd_ctrl_top, byte stream in, host responder on the bus
 * host ack delay of 0 to 3 clk is drawn from a fixed-seed lfsr
 */
`include "osd_config.svh"

module tb_osd_ctrl;
   timeunit 1ns;
   timeprecision 100ps;

   import osd_pkg::*;

   // about 150 clk of stimulus, each write can stall 4 clk, wide margin
   localparam int TIMEOUT_CYCLES = 2000;

   logic       clk = 1'b0;
   logic       reset;
   logic       byte_valid;
   logic       byte_is_cmd;
   osd_byte_t  byte_data;
   osd_byte_t  osd_ctrl;
   osd_byte_t  rd_data;
   logic       usrrst;
   logic       cpurst;
   logic       cpuhlt;
   logic       osd_enable;
   logic       key_disable;
   logic [1:0] scanline;
   logic [1:0] lr_filter;
   logic [1:0] hr_filter;
   logic [1:0] dither;
   logic [4:0] chipset_config;
   logic [6:0] memory_config;
   logic       fifo_full;
   logic       host_cs;
   logic       host_we;
   logic [1:0] host_bs;
   osd_addr_t  host_adr;
   osd_word_t  host_wdat;
   logic       host_ack = 1'b0;

   int          err_cnt = 0;
   int          cycle_cnt = 0;
   int          ack_wait = -1;
   logic        hold_ack = 1'b0;
   logic [31:0] lfsr_state = 32'd83712;
   osd_addr_t   wr_adr_q[$];
   osd_word_t   wr_dat_q[$];

   osd_ctrl_top uut (.*);

   initial begin
      forever #4 clk = ~clk;
   end

   // --------------------
   // helpers
   // --------------------
   // galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   // one lfsr step per bit taken
   function automatic int take_bits(input int n);
      int v;
      v = 0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
      return v;
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         err_cnt++;
         $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
      end
   endtask

   // one byte for one clk, returns 1 ns after the sampling edge
   task automatic drive_byte(input logic is_cmd, input osd_byte_t b);
      byte_valid  = 1'b1;
      byte_is_cmd = is_cmd;
      byte_data   = b;
      @(posedge clk);
      #1;
      byte_valid  = 1'b0;
      byte_is_cmd = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_writes(input int n);
      while (wr_adr_q.size() < n) begin
         idle(1);
      end
   endtask

   // --------------------
   // host responder and write log
   // --------------------
   always @(posedge clk) begin
      #1;
      if (!host_cs || hold_ack) begin
         host_ack = 1'b0;
         ack_wait = -1;
      end else if (host_ack) begin
         host_ack = 1'b0;
      end else begin
         if (ack_wait < 0)
            ack_wait = take_bits(2);
         else
            ack_wait--;
         host_ack = (ack_wait == 0);
      end
   end

   // a write ends on the ack clk
   always @(posedge clk) begin
      if (!reset && host_cs && host_ack) begin
         wr_adr_q.push_back(host_adr);
         wr_dat_q.push_back(host_wdat);
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run still busy after %0d clk", TIMEOUT_CYCLES);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // --------------------
   // stimulus
   // --------------------
   initial begin
      osd_byte_t d;
      int        chk_fails;
      reset       = 1'b1;
      byte_valid  = 1'b0;
      byte_is_cmd = 1'b0;
      byte_data   = 8'h00;
      osd_ctrl    = 8'h5a;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      // values out of reset
      check_eq("{cpuhlt,cpurst,usrrst}", 32'({cpuhlt, cpurst, usrrst}), 32'b110);
      check_eq("{key_disable,osd_enable}", 32'({key_disable, osd_enable}), 32'b00);
      check_eq("host_cs", 32'(host_cs), 32'd0);
      check_eq("{host_we,host_bs}", 32'({host_we, host_bs}), 32'd0);
      check_eq("fifo_full", 32'(fifo_full), 32'd0);
      check_eq("memory_config", 32'(memory_config), 32'(`OSD_MEMORY_CFG_RESET));

      // immediate registers, second payload byte is ignored
      d = 8'h03;
      drive_byte(1'b1, {`OSD_CMD_RESET_CTRL, 2'b00});
      drive_byte(1'b0, d);
      check_eq("{cpuhlt,cpurst,usrrst}", 32'({cpuhlt, cpurst, usrrst}), 32'(d[2:0]));
      drive_byte(1'b0, 8'h02);
      check_eq("{cpuhlt,cpurst,usrrst}", 32'({cpuhlt, cpurst, usrrst}), 32'(d[2:0]));
      d = 8'h02;
      drive_byte(1'b1, {`OSD_CMD_OSD_CTRL, 2'b00});
      drive_byte(1'b0, d);
      check_eq("{key_disable,osd_enable}", 32'({key_disable, osd_enable}), 32'(d[1:0]));
      drive_byte(1'b0, 8'h01);
      check_eq("{key_disable,osd_enable}", 32'({key_disable, osd_enable}), 32'(d[1:0]));
      d = 8'he4;
      drive_byte(1'b1, {`OSD_CMD_VIDEO_CFG, 2'b00});
      drive_byte(1'b0, d);
      check_eq("{dither,hr,lr,scanline}", 32'({dither, hr_filter, lr_filter, scanline}), 32'(d));
      drive_byte(1'b0, 8'h1b);
      check_eq("{dither,hr,lr,scanline}", 32'({dither, hr_filter, lr_filter, scanline}), 32'(d));

      // version bytes by count 0 to 3, then back to osd_ctrl
      drive_byte(1'b1, {`OSD_CMD_VERSION, 2'b00});
      check_eq("rd_data", 32'(rd_data), 32'(`OSD_VER_BETA));
      drive_byte(1'b0, 8'h00);
      check_eq("rd_data", 32'(rd_data), 32'(`OSD_VER_MAJOR));
      drive_byte(1'b0, 8'h00);
      check_eq("rd_data", 32'(rd_data), 32'(`OSD_VER_MINOR));
      drive_byte(1'b0, 8'h00);
      check_eq("rd_data", 32'(rd_data), 32'(`OSD_VER_SEP));
      drive_byte(1'b1, {`OSD_CMD_OSD_CTRL, 2'b00});
      osd_ctrl = 8'hc3;
      idle(1);
      check_eq("rd_data", 32'(rd_data), 32'(osd_ctrl));

      // staged config waits for a reset pulse
      drive_byte(1'b1, {`OSD_CMD_CHIP_CFG, 2'b00});
      drive_byte(1'b0, 8'h15);
      drive_byte(1'b1, {`OSD_CMD_MEMORY_CFG, 2'b00});
      drive_byte(1'b0, 8'h3a);
      idle(2);
      check_eq("chipset_config", 32'(chipset_config), 32'h00);
      check_eq("memory_config", 32'(memory_config), 32'(`OSD_MEMORY_CFG_RESET));
      reset = 1'b1;
      idle(1);
      reset = 1'b0;
      check_eq("chipset_config", 32'(chipset_config), 32'h15);
      check_eq("memory_config", 32'(memory_config), 32'h3a);

      // memory write: address 051234, page byte, three words
      drive_byte(1'b1, {`OSD_CMD_MEM_WRITE, 2'b00});
      drive_byte(1'b0, 8'h34);
      drive_byte(1'b0, 8'h12);
      drive_byte(1'b0, 8'h05);
      drive_byte(1'b0, 8'h77);
      for (int i = 0; i < 6; i++) begin
         drive_byte(1'b0, 8'(8'h11 * (i + 1)));
      end
      wait_writes(3);
      for (int i = 0; i < 3; i++) begin
         check_eq("host_adr", 32'(wr_adr_q[i]), 32'h05_1234 + 32'(2 * i));
         check_eq("host_wdat", 32'(wr_dat_q[i]),
                  32'({8'(8'h11 * (2 * i + 1)), 8'(8'h11 * (2 * i + 2))}));
      end

      // abort a write that waits for ack, bus is idle here
      hold_ack = 1'b1;
      drive_byte(1'b1, {`OSD_CMD_MEM_WRITE, 2'b00});
      drive_byte(1'b0, 8'h00);
      drive_byte(1'b0, 8'h40);
      drive_byte(1'b0, 8'h00);
      drive_byte(1'b0, 8'h00);
      drive_byte(1'b0, 8'haa);
      drive_byte(1'b0, 8'hbb);
      while (!host_cs) begin
         idle(1);
      end
      idle(2);
      drive_byte(1'b1, {`OSD_CMD_VERSION, 2'b00});
      idle(1);
      check_eq("host_cs", 32'(host_cs), 32'd0);
      check_eq("host write count", 32'(wr_adr_q.size()), 32'd3);
      @(negedge clk);
      hold_ack = 1'b0;
      @(posedge clk);
      #1;
      // word stays queued, written again at the same address
      wait_writes(4);
      check_eq("host_adr", 32'(wr_adr_q[3]), 32'h00_4000);
      check_eq("host_wdat", 32'(wr_dat_q[3]), 32'haabb);
      idle(10);
      check_eq("host write count", 32'(wr_adr_q.size()), 32'd4);

      chk_fails = int'(uut.u_checker.fail_cnt);
      $display("errors: %0d value check(s), %0d assertion failure(s)", err_cnt, chk_fails);
      if (err_cnt == 0 && chk_fails == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+.
osd_pkg.sv
osd_cmd_decoder.sv
osd_config_regs.sv
osd_word_fifo.sv
osd_host_writer.sv
osd_ctrl_top.sv
osd_ctrl_checker.sv
tb_osd_ctrl.sv

/* Makefile */
# Verilator flow for the osd command controller
# all variables can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_osd_ctrl
RTL_TOP   ?= osd_ctrl_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)
SRCS    := $(wildcard *.sv *.svh) $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
